// File: logic/cam_bist_params.svh
`ifndef CAM_BIST_PARAMS_SVH
`define CAM_BIST_PARAMS_SVH

// CAM array geometry
`define CAM_WIDTH    16
`define CAM_ENTRIES  16
`define CAM_ADDR_W   4

// APB register map, byte offsets
`define REG_CTRL      8'h00
`define REG_PATTERN   8'h04
`define REG_STATUS    8'h08
`define REG_FAIL_CNT  8'h0C

`endif

// File: logic/cam_bist_pkg.sv
`default_nettype none

package cam_bist_pkg;

   // Phases of one BIST run
   typedef enum logic [1:0] {
      IDLE    = 2'd0,
      WRITE   = 2'd1,
      COMPARE = 2'd2,
      DRAIN   = 2'd3
   } bist_phase_t;

   // CTRL register layout
   // Bit 0 start, bit 1 cd_mask_enable, bit 2 data_inv
   typedef struct packed {
      logic data_inv;
      logic cd_mask_enable;
      logic start;
   } bist_ctrl_t;

endpackage : cam_bist_pkg

`default_nettype wire

// File: logic/cam_bist_if.sv
`timescale 1ns/10ps
`default_nettype none

`include "cam_bist_params.svh"

interface cam_bist_if;

   // Test mode controls
   logic                   cm_mode;
   logic                   rotate_mask;
   logic                   cd_mask_enable;
   logic                   data_inv;

   // BIST write port
   logic                   bist_wr_en;
   logic [`CAM_ADDR_W-1:0] bist_wr_addr;
   logic [`CAM_WIDTH-1:0]  bist_wr_data;

   // Marks a search whose result the checker scores
   logic                   cmp_valid;

   modport seq (
      output cm_mode, rotate_mask, cd_mask_enable, data_inv,
      output bist_wr_en, bist_wr_addr, bist_wr_data, cmp_valid
   );

   modport hnd (
      input cm_mode, rotate_mask, cd_mask_enable, data_inv,
      input bist_wr_en, bist_wr_addr, bist_wr_data
   );

   modport mon (
      input cd_mask_enable, cmp_valid
   );

endinterface : cam_bist_if

`default_nettype wire

// File: logic/cam_bist_apb_regs.sv
`timescale 1ns/10ps
`default_nettype none

`include "cam_bist_params.svh"

module cam_bist_apb_regs
   import cam_bist_pkg::*;
(
   input  logic                  bist_clk,
   input  logic                  rst_b,
   input  logic                  psel,
   input  logic                  penable,
   input  logic                  pwrite,
   input  logic [7:0]            paddr,
   input  logic [31:0]           pwdata,
   output logic [31:0]           prdata,
   output logic                  pslverr,
   output logic                  start,
   output bist_ctrl_t            ctrl,
   output logic [`CAM_WIDTH-1:0] pattern,
   input  logic                  busy,
   input  logic                  done,
   input  logic [15:0]           fail_cnt
);

   logic                  access;
   logic                  wr_access;
   logic                  mapped;
   logic                  read_only;
   bist_ctrl_t            ctrl_q;
   logic [`CAM_WIDTH-1:0] pattern_q;

   // Access cycle of an APB transfer
   assign access    = psel & penable;
   assign wr_access = access & pwrite;

   // ---------------------------------------------------------------------
   // Address decode and read mux
   // ---------------------------------------------------------------------
   always_comb begin
      prdata    = '0;
      mapped    = 1'b1;
      read_only = 1'b0;
      case (paddr)
         // Start always reads back as zero
         `REG_CTRL: prdata[2:0] = {ctrl_q.data_inv, ctrl_q.cd_mask_enable, 1'b0};
         `REG_PATTERN: prdata[`CAM_WIDTH-1:0] = pattern_q;
         `REG_STATUS: begin
            // Fail flag stays up while any failure is counted
            prdata[2:0] = {|fail_cnt, done, busy};
            read_only   = 1'b1;
         end
         `REG_FAIL_CNT: begin
            prdata[15:0] = fail_cnt;
            read_only    = 1'b1;
         end
         default: mapped = 1'b0;
      endcase
   end

   // Error on unmapped offset or on a write to a read-only register
   assign pslverr = access & (~mapped | (pwrite & read_only));

   // ---------------------------------------------------------------------
   // Writable registers
   // ---------------------------------------------------------------------
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         ctrl_q    <= '0;
         pattern_q <= '0;
      end else begin
         // Start field lasts a single cycle
         ctrl_q.start <= 1'b0;
         if (wr_access && paddr == `REG_CTRL) begin
            ctrl_q.start          <= pwdata[0];
            ctrl_q.cd_mask_enable <= pwdata[1];
            ctrl_q.data_inv       <= pwdata[2];
         end
         if (wr_access && paddr == `REG_PATTERN) begin
            pattern_q <= pwdata[`CAM_WIDTH-1:0];
         end
      end
   end

   assign start   = ctrl_q.start;
   assign ctrl    = ctrl_q;
   assign pattern = pattern_q;

endmodule : cam_bist_apb_regs

`default_nettype wire

// File: logic/cam_bist_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

`include "cam_bist_params.svh"

module cam_bist_sequencer
   import cam_bist_pkg::*;
(
   input  logic                  bist_clk,
   input  logic                  rst_b,
   input  logic                  start,
   input  bist_ctrl_t            ctrl,
   input  logic [`CAM_WIDTH-1:0] pattern,
   output logic                  busy,
   output logic                  done,
   cam_bist_if.seq               bus
);

   localparam int BIT_W = $clog2(`CAM_WIDTH);

   bist_phase_t            phase;
   logic [`CAM_ADDR_W-1:0] ent_cnt;
   logic [BIT_W-1:0]       bit_cnt;
   logic                   drain_cnt;
   logic                   busy_q;
   logic                   done_q;

   // ---------------------------------------------------------------------
   // Phase FSM
   // ---------------------------------------------------------------------
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         phase     <= IDLE;
         ent_cnt   <= '0;
         bit_cnt   <= '0;
         drain_cnt <= 1'b0;
         busy_q    <= 1'b0;
         done_q    <= 1'b0;
      end else if (start && !busy_q) begin
         // New run, a start while busy is dropped
         phase   <= WRITE;
         ent_cnt <= '0;
         busy_q  <= 1'b1;
         done_q  <= 1'b0;
      end else begin
         case (phase)
            WRITE: begin
               // One entry per cycle
               ent_cnt <= ent_cnt + 1'b1;
               if (ent_cnt == `CAM_ENTRIES - 1) begin
                  phase   <= COMPARE;
                  bit_cnt <= '0;
               end
            end
            COMPARE: begin
               // One search per data bit
               bit_cnt <= bit_cnt + 1'b1;
               if (bit_cnt == `CAM_WIDTH - 1) begin
                  phase     <= DRAIN;
                  drain_cnt <= 1'b0;
               end
            end
            DRAIN: begin
               drain_cnt <= 1'b1;
               if (!drain_cnt) begin
                  // Last count lands here, report the run complete
                  busy_q <= 1'b0;
                  done_q <= 1'b1;
               end else begin
                  phase <= IDLE;
               end
            end
            default: ;
         endcase
      end
   end

   assign busy = busy_q;
   assign done = done_q;

   // ---------------------------------------------------------------------
   // Stimulus to the input handler and checker
   // ---------------------------------------------------------------------
   assign bus.bist_wr_en     = (phase == WRITE);
   assign bus.bist_wr_addr   = ent_cnt;
   assign bus.bist_wr_data   = pattern;

   // Compare mode and valid share the same window
   assign bus.cm_mode        = (phase == COMPARE);
   assign bus.cmp_valid      = (phase == COMPARE);
   // First search uses the mask as it stands
   assign bus.rotate_mask    = (phase == COMPARE) && (bit_cnt != '0);

   assign bus.cd_mask_enable = ctrl.cd_mask_enable;
   assign bus.data_inv       = ctrl.data_inv;

endmodule : cam_bist_sequencer

`default_nettype wire

// File: logic/cam_bist_inhandler.sv
`timescale 1ns/10ps
`default_nettype none

`include "cam_bist_params.svh"

module cam_bist_inhandler (
   input  logic                   bist_clk,
   input  logic                   rst_b,
   cam_bist_if.hnd                bus,
   input  logic                   mis_wr_en,
   input  logic [`CAM_ADDR_W-1:0] mis_wr_addr,
   input  logic [`CAM_WIDTH-1:0]  mis_wr_data,
   input  logic [`CAM_WIDTH-1:0]  mis_key,
   output logic                   cam_wr_en,
   output logic [`CAM_ADDR_W-1:0] cam_wr_addr,
   output logic [`CAM_WIDTH-1:0]  cam_wr_data,
   output logic [`CAM_WIDTH-1:0]  cam_key
);

   logic [`CAM_WIDTH-1:0] mask;
   logic [`CAM_WIDTH-1:0] bist_data;
   logic [`CAM_WIDTH-1:0] cmp_key;

   // One-hot walking mask, rotates left with wrap
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         mask <= {{(`CAM_WIDTH-1){1'b0}}, 1'b1};
      end else if (bus.rotate_mask) begin
         mask <= {mask[`CAM_WIDTH-2:0], mask[`CAM_WIDTH-1]};
      end
   end

   // Background word, optionally inverted
   assign bist_data = bus.bist_wr_data ^ {`CAM_WIDTH{bus.data_inv}};

   // Flip the walking bit when masking is on
   assign cmp_key = bist_data ^ (mask & {`CAM_WIDTH{bus.cd_mask_enable}});

   // ---------------------------------------------------------------------
   // BIST or mission selection
   // ---------------------------------------------------------------------
   assign cam_key     = bus.cm_mode ? cmp_key : mis_key;

   // Mission writes go through when BIST is not writing
   assign cam_wr_en   = bus.bist_wr_en | mis_wr_en;
   assign cam_wr_addr = bus.bist_wr_en ? bus.bist_wr_addr : mis_wr_addr;
   assign cam_wr_data = bus.bist_wr_en ? bist_data : mis_wr_data;

endmodule : cam_bist_inhandler

`default_nettype wire

// File: logic/cam_array.sv
`timescale 1ns/10ps
`default_nettype none

`include "cam_bist_params.svh"

module cam_array (
   input  logic                   bist_clk,
   input  logic                   rst_b,
   input  logic                   wr_en,
   input  logic [`CAM_ADDR_W-1:0] wr_addr,
   input  logic [`CAM_WIDTH-1:0]  wr_data,
   input  logic [`CAM_WIDTH-1:0]  key,
   output logic [`CAM_ENTRIES-1:0] match
);

   logic [`CAM_WIDTH-1:0]   mem [`CAM_ENTRIES];
   logic [`CAM_ENTRIES-1:0] valid;

   // ---------------------------------------------------------------------
   // Write port
   // ---------------------------------------------------------------------
   always_ff @(posedge bist_clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // Entry becomes valid on its first write
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         valid <= '0;
      end else if (wr_en) begin
         valid[wr_addr] <= 1'b1;
      end
   end

   // ---------------------------------------------------------------------
   // Search, result one cycle after the key
   // ---------------------------------------------------------------------
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         match <= '0;
      end else begin
         for (int e = 0; e < `CAM_ENTRIES; e++) begin
            // Compare against stored word before this cycle's write
            match[e] <= valid[e] && (mem[e] == key);
         end
      end
   end

endmodule : cam_array

`default_nettype wire

// File: logic/cam_match_checker.sv
`timescale 1ns/10ps
`default_nettype none

`include "cam_bist_params.svh"

module cam_match_checker (
   input  logic                    bist_clk,
   input  logic                    rst_b,
   input  logic [`CAM_ENTRIES-1:0] match,
   cam_bist_if.mon                 bus,
   output logic [15:0]             fail_cnt
);

   logic                    valid_d;
   logic                    mask_en_d;
   logic [`CAM_ENTRIES-1:0] expected;
   logic                    run_start;

   // Line up search controls with the registered match vector
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         valid_d   <= 1'b0;
         mask_en_d <= 1'b0;
      end else begin
         valid_d   <= bus.cmp_valid;
         mask_en_d <= bus.cd_mask_enable;
      end
   end

   // Masked key misses every entry, unmasked key hits all of them
   assign expected  = mask_en_d ? '0 : '1;

   // First compare cycle of a run
   assign run_start = bus.cmp_valid & ~valid_d;

   // Failure counter, saturates at all ones
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         fail_cnt <= '0;
      end else if (run_start) begin
         fail_cnt <= '0;
      end else if (valid_d && match != expected && fail_cnt != 16'hFFFF) begin
         fail_cnt <= fail_cnt + 16'd1;
      end
   end

endmodule : cam_match_checker

`default_nettype wire

// File: logic/cam_bist_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "cam_bist_params.svh"

module cam_bist_top
   import cam_bist_pkg::*;
(
   input  logic                    bist_clk,
   input  logic                    rst_b,
   // APB slave
   input  logic                    psel,
   input  logic                    penable,
   input  logic                    pwrite,
   input  logic [7:0]              paddr,
   input  logic [31:0]             pwdata,
   output logic [31:0]             prdata,
   output logic                    pslverr,
   // Mission port
   input  logic                    mis_wr_en,
   input  logic [`CAM_ADDR_W-1:0]  mis_wr_addr,
   input  logic [`CAM_WIDTH-1:0]   mis_wr_data,
   input  logic [`CAM_WIDTH-1:0]   mis_key,
   output logic [`CAM_ENTRIES-1:0] mis_match
);

   logic                   start;
   bist_ctrl_t             ctrl;
   logic [`CAM_WIDTH-1:0]  pattern;
   logic                   busy;
   logic                   done;
   logic [15:0]            fail_cnt;
   logic                   cam_wr_en;
   logic [`CAM_ADDR_W-1:0] cam_wr_addr;
   logic [`CAM_WIDTH-1:0]  cam_wr_data;
   logic [`CAM_WIDTH-1:0]  cam_key;

   // Stimulus bundle
   cam_bist_if bist_bus ();

   // ---------------------------------------------------------------------
   // Control path
   // ---------------------------------------------------------------------
   cam_bist_apb_regs u_regs (
      .bist_clk (bist_clk),
      .rst_b    (rst_b),
      .psel     (psel),
      .penable  (penable),
      .pwrite   (pwrite),
      .paddr    (paddr),
      .pwdata   (pwdata),
      .prdata   (prdata),
      .pslverr  (pslverr),
      .start    (start),
      .ctrl     (ctrl),
      .pattern  (pattern),
      .busy     (busy),
      .done     (done),
      .fail_cnt (fail_cnt)
   );

   cam_bist_sequencer u_seq (
      .bist_clk (bist_clk),
      .rst_b    (rst_b),
      .start    (start),
      .ctrl     (ctrl),
      .pattern  (pattern),
      .busy     (busy),
      .done     (done),
      .bus      (bist_bus.seq)
   );

   // ---------------------------------------------------------------------
   // Data path
   // ---------------------------------------------------------------------
   cam_bist_inhandler u_hnd (
      .bist_clk    (bist_clk),
      .rst_b       (rst_b),
      .bus         (bist_bus.hnd),
      .mis_wr_en   (mis_wr_en),
      .mis_wr_addr (mis_wr_addr),
      .mis_wr_data (mis_wr_data),
      .mis_key     (mis_key),
      .cam_wr_en   (cam_wr_en),
      .cam_wr_addr (cam_wr_addr),
      .cam_wr_data (cam_wr_data),
      .cam_key     (cam_key)
   );

   // Match vector serves the mission port and the checker
   cam_array u_cam (
      .bist_clk (bist_clk),
      .rst_b    (rst_b),
      .wr_en    (cam_wr_en),
      .wr_addr  (cam_wr_addr),
      .wr_data  (cam_wr_data),
      .key      (cam_key),
      .match    (mis_match)
   );

   cam_match_checker u_chk (
      .bist_clk (bist_clk),
      .rst_b    (rst_b),
      .match    (mis_match),
      .bus      (bist_bus.mon),
      .fail_cnt (fail_cnt)
   );

endmodule : cam_bist_top

`default_nettype wire

// File: test/cam_bist_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "cam_bist_params.svh"

module cam_bist_tb
   import cam_bist_pkg::*;
();

   // Start pulse to done, in clock cycles
   localparam int unsigned RUN_CYCLES = `CAM_ENTRIES + `CAM_WIDTH + 2;
   localparam int unsigned NUM_RUNS = 4;
   localparam int unsigned WATCHDOG_CYCLES = 40 * (`CAM_ENTRIES + `CAM_WIDTH + 10) * NUM_RUNS;
   localparam logic [31:0] RAND_SEED = 32'hcd4c_682c;

   logic                    bist_clk;
   logic                    rst_b;
   logic                    psel;
   logic                    penable;
   logic                    pwrite;
   logic [7:0]              paddr;
   logic [31:0]             pwdata;
   logic [31:0]             prdata;
   logic                    pslverr;
   logic                    mis_wr_en;
   logic [`CAM_ADDR_W-1:0]  mis_wr_addr;
   logic [`CAM_WIDTH-1:0]   mis_wr_data;
   logic [`CAM_WIDTH-1:0]   mis_key;
   logic [`CAM_ENTRIES-1:0] mis_match;

   // Free running cycle count, for latency checks
   int unsigned             cycle;

   // Reference copy of the CAM contents
   logic [`CAM_WIDTH-1:0]   model_word [`CAM_ENTRIES];
   logic [`CAM_ENTRIES-1:0] model_valid;

   cam_bist_top uut (
      .bist_clk    (bist_clk),
      .rst_b       (rst_b),
      .psel        (psel),
      .penable     (penable),
      .pwrite      (pwrite),
      .paddr       (paddr),
      .pwdata      (pwdata),
      .prdata      (prdata),
      .pslverr     (pslverr),
      .mis_wr_en   (mis_wr_en),
      .mis_wr_addr (mis_wr_addr),
      .mis_wr_data (mis_wr_data),
      .mis_key     (mis_key),
      .mis_match   (mis_match)
   );

   initial begin
      bist_clk = 1'b0;
      forever #50 bist_clk = ~bist_clk;
   end

   always @(posedge bist_clk) begin
      cycle <= cycle + 1;
   end

   // ----------------------------------------------------------------------
   // Error reporting
   // ----------------------------------------------------------------------
   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("** FAIL **");
      $fatal(1, "Simulation stopped on the first error");
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      string line;
      line = $sformatf("CHECK FAILED at %0d ns: %s = 0x%0h, expected 0x%0h",
                       $time, name, got, exp);
      stop_with_failure(line);
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp) else report_mismatch(name, got, exp);
   endtask

   // ----------------------------------------------------------------------
   // Protocol and timing properties
   // ----------------------------------------------------------------------
   // Slave error only in an access cycle
   pslverr_in_access: assert property (@(posedge bist_clk) pslverr |-> (psel && penable))
      else report_mismatch("pslverr", $sampled(pslverr), 0);

   // Busy drops in the cycle done rises
   done_not_busy: assert property (@(posedge bist_clk) disable iff (!rst_b)
                                   uut.done |-> !uut.busy)
      else report_mismatch("uut.busy", $sampled(uut.busy), 0);

   // Mask rotates in every compare cycle except the first
   rotate_after_first: assert property (@(posedge bist_clk) disable iff (!rst_b)
      uut.bist_bus.rotate_mask == (uut.bist_bus.cm_mode && $past(uut.bist_bus.cm_mode)))
      else report_mismatch("rotate_mask", $sampled(uut.bist_bus.rotate_mask),
                           !$sampled(uut.bist_bus.rotate_mask));

   // ----------------------------------------------------------------------
   // APB and mission port drivers
   // ----------------------------------------------------------------------
   task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                            output logic err);
      @(posedge bist_clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b1;
      paddr   <= addr;
      pwdata  <= data;
      @(posedge bist_clk);
      penable <= 1'b1;
      // Mid access cycle
      @(negedge bist_clk);
      err = pslverr;
      @(posedge bist_clk);
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
   endtask

   task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                           output logic err);
      @(posedge bist_clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b0;
      paddr   <= addr;
      @(posedge bist_clk);
      penable <= 1'b1;
      @(negedge bist_clk);
      data = prdata;
      err  = pslverr;
      @(posedge bist_clk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic mission_write(input logic [`CAM_ADDR_W-1:0] addr,
                                input logic [`CAM_WIDTH-1:0] data);
      @(posedge bist_clk);
      mis_wr_en   <= 1'b1;
      mis_wr_addr <= addr;
      mis_wr_data <= data;
      @(posedge bist_clk);
      mis_wr_en   <= 1'b0;
   endtask

   // Match vector is registered, read it one cycle after the key
   task automatic mission_search(input logic [`CAM_WIDTH-1:0] key,
                                 output logic [`CAM_ENTRIES-1:0] match);
      @(posedge bist_clk);
      mis_key <= key;
      @(posedge bist_clk);
      @(negedge bist_clk);
      match = mis_match;
   endtask

   // An entry hits when valid and its word equals the key
   function automatic logic [`CAM_ENTRIES-1:0] expected_match(input logic [`CAM_WIDTH-1:0] key);
      logic [`CAM_ENTRIES-1:0] m;
      for (int e = 0; e < `CAM_ENTRIES; e++) begin
         m[e] = model_valid[e] && (model_word[e] == key);
      end
      return m;
   endfunction

   // ----------------------------------------------------------------------
   // BIST run control
   // ----------------------------------------------------------------------
   task automatic start_run(input bist_ctrl_t c, output int unsigned start_cyc);
      logic err;
      apb_write(`REG_CTRL, {29'd0, c}, err);
      check_value("pslverr", err, 0);
      // Start pulse follows the access cycle
      @(negedge bist_clk);
      start_cyc = cycle;
      check_value("uut.start", uut.start, 1);
   endtask

   task automatic wait_done(input int unsigned start_cyc);
      @(negedge bist_clk);
      while (uut.done !== 1'b1) begin
         if (cycle - start_cyc > 4 * RUN_CYCLES) begin
            stop_with_failure("The BIST run never raised done");
         end
         // Run stays busy until done
         check_value("uut.busy", uut.busy, 1);
         @(negedge bist_clk);
      end
      check_value("done latency", cycle - start_cyc, RUN_CYCLES);
      check_value("uut.busy", uut.busy, 0);
   endtask

   task automatic run_bist(input logic mask_en, input logic inv, input logic restart,
                           output logic [`CAM_WIDTH-1:0] pat);
      logic [31:0] rdata;
      logic        err;
      bist_ctrl_t  ctrl_w;
      int unsigned start_cyc;
      pat = $urandom();
      apb_write(`REG_PATTERN, {16'h0, pat}, err);
      check_value("pslverr", err, 0);
      ctrl_w.start          = 1'b1;
      ctrl_w.cd_mask_enable = mask_en;
      ctrl_w.data_inv       = inv;
      start_run(ctrl_w, start_cyc);
      // Second start lands while busy
      if (restart) begin
         apb_write(`REG_CTRL, {29'd0, ctrl_w}, err);
         check_value("pslverr", err, 0);
      end
      apb_read(`REG_CTRL, rdata, err);
      check_value("CTRL", rdata, {29'd0, inv, mask_en, 1'b0});
      wait_done(start_cyc);
      // Done set, busy and fail clear
      apb_read(`REG_STATUS, rdata, err);
      check_value("STATUS", rdata, 32'h2);
      apb_read(`REG_FAIL_CNT, rdata, err);
      check_value("FAIL_CNT", rdata, 0);
      for (int e = 0; e < `CAM_ENTRIES; e++) begin
         model_word[e] = inv ? ~pat : pat;
      end
      model_valid = '1;
   endtask

   // ----------------------------------------------------------------------
   // Main sequence
   // ----------------------------------------------------------------------
   initial begin
      logic [31:0]             rdata;
      logic                    err;
      logic [`CAM_WIDTH-1:0]   pat;
      logic [`CAM_WIDTH-1:0]   word;
      logic [`CAM_ADDR_W-1:0]  addr;
      logic [`CAM_ENTRIES-1:0] match;
      bist_ctrl_t              ctrl_w;
      void'($urandom(RAND_SEED));
      rst_b       = 1'b0;
      psel        = 1'b0;
      penable     = 1'b0;
      pwrite      = 1'b0;
      paddr       = '0;
      pwdata      = '0;
      mis_wr_en   = 1'b0;
      mis_wr_addr = '0;
      mis_wr_data = '0;
      mis_key     = '0;
      cycle       = 0;
      model_valid = '0;
      repeat (10) @(posedge bist_clk);
      rst_b <= 1'b1;

      // Reset values
      @(negedge bist_clk);
      check_value("pslverr", pslverr, 0);
      check_value("mis_match", mis_match, 0);
      apb_read(`REG_STATUS, rdata, err);
      check_value("STATUS", rdata, 0);
      apb_read(`REG_FAIL_CNT, rdata, err);
      check_value("FAIL_CNT", rdata, 0);

      // Read back of writable registers
      pat  = $urandom();
      word = $urandom();
      apb_write(`REG_PATTERN, {word, pat}, err);
      apb_read(`REG_PATTERN, rdata, err);
      check_value("PATTERN", rdata, {16'h0, pat});
      check_value("pslverr", err, 0);
      ctrl_w = 3'b110;
      apb_write(`REG_CTRL, {29'd0, ctrl_w}, err);
      apb_read(`REG_CTRL, rdata, err);
      check_value("CTRL", rdata, 32'h6);

      // Slave errors, read only registers stay put
      apb_read(8'h10, rdata, err);
      check_value("pslverr", err, 1);
      apb_write(8'h20, 32'h1, err);
      check_value("pslverr", err, 1);
      apb_write(`REG_STATUS, 32'h7, err);
      check_value("pslverr", err, 1);
      apb_write(`REG_FAIL_CNT, 32'hffff, err);
      check_value("pslverr", err, 1);
      apb_read(`REG_STATUS, rdata, err);
      check_value("STATUS", rdata, 0);

      // Unmasked, then masked with and without inversion
      run_bist(1'b0, 1'b0, 1'b0, pat);
      run_bist(1'b1, 1'b0, 1'b0, pat);
      run_bist(1'b1, 1'b1, 1'b0, pat);

      // Array now holds the inverted background
      mission_search(~pat, match);
      check_value("mis_match", match, {`CAM_ENTRIES{1'b1}});
      mission_search(pat, match);
      check_value("mis_match", match, '0);

      // Mission write and search through the input handler
      addr = $urandom();
      word = $urandom();
      mission_write(addr, word);
      model_word[addr] = word;
      mission_search(word, match);
      check_value("mis_match", match, expected_match(word));
      check_value("mis_match[addr]", match[addr], 1);
      word = $urandom();
      mission_search(word, match);
      check_value("mis_match", match, expected_match(word));

      // Start while busy must not restart the run
      run_bist(1'b0, 1'b1, 1'b1, pat);

      $display("** PASS **");
      $finish;
   end

   // Watchdog
   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge bist_clk);
      stop_with_failure($sformatf("Timeout: the test did not finish within %0d cycles",
                                  WATCHDOG_CYCLES));
   end

endmodule : cam_bist_tb

`default_nettype wire

// File: sim.f
+incdir+logic
logic/cam_bist_pkg.sv
logic/cam_bist_if.sv
logic/cam_bist_apb_regs.sv
logic/cam_bist_sequencer.sv
logic/cam_bist_inhandler.sv
logic/cam_array.sv
logic/cam_match_checker.sv
logic/cam_bist_top.sv
test/cam_bist_tb.sv

// File: Bender.yml
package:
  name: cam_bist

sources:
  - include_dirs:
      - logic
    files:
      - logic/cam_bist_pkg.sv
      - logic/cam_bist_if.sv
      - logic/cam_bist_apb_regs.sv
      - logic/cam_bist_sequencer.sv
      - logic/cam_bist_inhandler.sv
      - logic/cam_array.sv
      - logic/cam_match_checker.sv
      - logic/cam_bist_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - test/cam_bist_tb.sv
